// File: hw/pktDemoPkg.sv
`default_nettype none

package pktDemoPkg;

  //--- Host bus ---------------------------------------------------------------

  localparam int ADR_W = 15;
  localparam int DAT_W = 16;

  // Region select, address bits 14:13
  localparam logic [1:0] REG_SCRATCH  = 2'd0;
  localparam logic [1:0] REG_PDM      = 2'd1;
  localparam logic [1:0] REG_GEN      = 2'd2;
  localparam logic [1:0] REG_UNMAPPED = 2'd3;

  // Generator register offsets, address bit 0
  localparam logic GEN_CTRL = 1'b0;
  localparam logic GEN_STAT = 1'b1;

  // Scratch register reset values
  localparam logic [DAT_W-1:0] SCRATCH0_RST = 16'h1234;
  localparam logic [DAT_W-1:0] SCRATCH1_RST = 16'hABCD;

  //--- Packet descriptors -----------------------------------------------------

  localparam int DESC_DEPTH  = 64;
  localparam int DESC_AW     = 6;
  localparam int LEN_W       = 11;
  localparam int FRAME_CNT_W = 7;

  // Zero length is sent as one byte
  typedef struct packed {
    logic             last;
    logic [11:0]      rsvd;
    logic [7:0]       seed;
    logic [LEN_W-1:0] len;
  } desc_t;

  //--- Transmit word path -----------------------------------------------------

  // First byte in data[7:0]
  // be counts valid bytes on eop, 0 means all four
  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [1:0]  be;
    logic [31:0] data;
  } macWord_t;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // Minimum idle cycles between frames
  localparam int IFG_CYCLES = 12;

endpackage

`default_nettype wire

// File: hw/pktDemoIfs.sv
`default_nettype none

// Shared host bus request lines
// Strobe, read data and ack stay per client
interface hostBusIf;
  import pktDemoPkg::*;

  logic             cyc;
  logic [ADR_W-1:0] adr;
  logic             we;
  logic [DAT_W-1:0] datWr;

  modport decoder (output cyc, adr, we, datWr);
  modport client  (input cyc, adr, we, datWr);

endinterface

// MAC-side word handshake
// A word moves when wr and ready are both high
interface macWordIf;
  import pktDemoPkg::*;

  logic     ready;
  logic     wr;
  macWord_t word;

  // Sender drives the word and its strobe
  modport sender (input ready, output wr, word);

  // Receiver drives the ready level
  modport receiver (output ready, input wr, word);

endinterface

`default_nettype wire

// File: hw/hostBusDecoder.sv
`default_nettype none

module hostBusDecoder (
  input  wire                         Clk,
  input  wire                         reset_i,
  input  wire                         cyc_i,
  input  wire                         stb_i,
  input  wire                         we_i,
  input  wire [pktDemoPkg::ADR_W-1:0] adr_i,
  input  wire [pktDemoPkg::DAT_W-1:0] dat_i,
  output logic [pktDemoPkg::DAT_W-1:0] dat_o,
  output logic                        ack_o,
  hostBusIf.decoder                   bus,
  output logic                        pdmStb_o,
  output logic                        genStb_o,
  input  wire [pktDemoPkg::DAT_W-1:0] pdmDat_i,
  input  wire                         pdmAck_i,
  input  wire [pktDemoPkg::DAT_W-1:0] genDat_i,
  input  wire                         genAck_i
);
  import pktDemoPkg::*;

  logic [1:0]       region;
  logic             req;
  logic             localReq;
  logic             localAck;
  logic [DAT_W-1:0] localDat;
  logic [DAT_W-1:0] scratch0;
  logic [DAT_W-1:0] scratch1;

  // Request lines go to every client unchanged
  assign bus.cyc   = cyc_i;
  assign bus.adr   = adr_i;
  assign bus.we    = we_i;
  assign bus.datWr = dat_i;

  //--- Region decode ----------------------------------------------------------

  assign region   = adr_i[ADR_W-1 -: 2];
  assign req      = cyc_i & stb_i;
  assign pdmStb_o = req & (region == REG_PDM);
  assign genStb_o = req & (region == REG_GEN);

  // Scratch and unmapped regions are answered here
  // No second ack in the cycle after our own
  assign localReq = req & ~localAck &
                    ((region == REG_SCRATCH) | (region == REG_UNMAPPED));

  always_ff @(posedge Clk)
  begin
    if (reset_i)
    begin
      localAck <= 1'b0;
      scratch0 <= SCRATCH0_RST;
      scratch1 <= SCRATCH1_RST;
    end
    else
    begin
      localAck <= localReq;
      // Unmapped writes fall through untouched
      if (localReq & we_i & (region == REG_SCRATCH))
      begin
        if (adr_i[0])
          scratch1 <= dat_i;
        else
          scratch0 <= dat_i;
      end
    end
  end

  // Read data, unmapped reads give zero
  always_ff @(posedge Clk)
  begin
    if (localReq & ~we_i)
    begin
      if (region == REG_SCRATCH)
        localDat <= adr_i[0] ? scratch1 : scratch0;
      else
        localDat <= '0;
    end
  end

  //--- Read data and ack merge ------------------------------------------------

  assign dat_o = ({DAT_W{localAck}} & localDat) |
                 ({DAT_W{pdmAck_i}} & pdmDat_i) |
                 ({DAT_W{genAck_i}} & genDat_i);

  assign ack_o = localAck | pdmAck_i | genAck_i;

endmodule

`default_nettype wire

// File: hw/descriptorMemory.sv
`default_nettype none

module descriptorMemory (
  input  wire                           Clk,
  input  wire                           reset_i,
  hostBusIf.client                      bus,
  input  wire                           stb_i,
  output logic [pktDemoPkg::DAT_W-1:0]  dat_o,
  output logic                          ack_o,
  input  wire                           rd_i,
  input  wire [pktDemoPkg::DESC_AW-1:0] addr_i,
  output pktDemoPkg::desc_t             rdData_o
);
  import pktDemoPkg::*;

  desc_t              mem [DESC_DEPTH];
  logic [DESC_AW-1:0] busIdx;
  logic               busHigh;
  logic               busReq;

  // Bits 6:1 pick the descriptor, bit 0 the half
  assign busIdx  = bus.adr[DESC_AW:1];
  assign busHigh = bus.adr[0];

  // One access per request
  assign busReq = stb_i & bus.cyc & ~ack_o;

  always_ff @(posedge Clk)
  begin
    if (reset_i)
      ack_o <= 1'b0;
    else
      ack_o <= busReq;
  end

  //--- Host side ---------------------------------------------------------------

  always_ff @(posedge Clk)
  begin
    if (busReq & bus.we)
    begin
      if (busHigh)
        mem[busIdx][2*DAT_W-1:DAT_W] <= bus.datWr;
      else
        mem[busIdx][DAT_W-1:0] <= bus.datWr;
    end
    if (busReq & ~bus.we)
      dat_o <= busHigh ? mem[busIdx][2*DAT_W-1:DAT_W] : mem[busIdx][DAT_W-1:0];
  end

  //--- Generator side ---------------------------------------------------------

  // Data valid the cycle after rd_i
  always_ff @(posedge Clk)
  begin
    if (rd_i)
      rdData_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// File: hw/packetGenerator.sv
`default_nettype none

module packetGenerator (
  input  wire                           Clk,
  input  wire                           reset_i,
  hostBusIf.client                      bus,
  input  wire                           stb_i,
  output logic [pktDemoPkg::DAT_W-1:0]  dat_o,
  output logic                          ack_o,
  output logic                          rd_o,
  output logic [pktDemoPkg::DESC_AW-1:0] addr_o,
  input  wire pktDemoPkg::desc_t        rdData_i,
  macWordIf.sender                      txOut
);
  import pktDemoPkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT,
    ST_EMIT
  } genState_t;

  genState_t              state;
  logic [DESC_AW-1:0]     descIdx;
  logic [FRAME_CNT_W-1:0] frameCnt;
  logic [LEN_W-1:0]       bytesLeft;
  logic [7:0]             byteBase;
  logic                   firstWord;
  logic                   lastDesc;
  logic                   busy;
  logic                   busReq;
  logic                   startReq;
  logic                   wordEop;
  logic                   wordDone;
  macWord_t               outWord;

  //--- Bus registers ----------------------------------------------------------

  assign busy   = (state != ST_IDLE);
  assign busReq = stb_i & bus.cyc & ~ack_o;

  // Start only from idle
  assign startReq = busReq & bus.we & (bus.adr[0] == GEN_CTRL) &
                    bus.datWr[0] & ~busy;

  // Status: busy on top, frame count below
  // Control reads back zero
  always_ff @(posedge Clk)
  begin
    if (busReq & ~bus.we)
    begin
      if (bus.adr[0] == GEN_STAT)
        dat_o <= {busy, {(DAT_W-1-FRAME_CNT_W){1'b0}}, frameCnt};
      else
        dat_o <= '0;
    end
  end

  //--- Word build -------------------------------------------------------------

  // Last word once four or fewer bytes remain
  always_comb
  begin
    wordEop      = (bytesLeft <= LEN_W'(4));
    outWord.sop  = firstWord;
    outWord.eop  = wordEop;
    outWord.be   = wordEop ? bytesLeft[1:0] : 2'd0;
    // Bytes count up from the seed
    for (int k = 0; k < 4; k++)
      outWord.data[8*k +: 8] = byteBase + 8'(k);
  end

  // Strobe only while the FIFO has room, word held otherwise
  assign txOut.wr   = (state == ST_EMIT) & txOut.ready;
  assign txOut.word = outWord;
  assign wordDone   = txOut.wr;

  // Descriptor fetch
  assign rd_o   = (state == ST_FETCH);
  assign addr_o = descIdx;

  //--- Control FSM ------------------------------------------------------------

  always_ff @(posedge Clk)
  begin
    if (reset_i)
    begin
      state    <= ST_IDLE;
      ack_o    <= 1'b0;
      descIdx  <= '0;
      frameCnt <= '0;
    end
    else
    begin
      ack_o <= busReq;
      case (state)
        ST_IDLE:
          if (startReq)
          begin
            state    <= ST_FETCH;
            descIdx  <= '0;
            frameCnt <= '0;
          end
        ST_FETCH:
          state <= ST_WAIT;
        // Descriptor lands this cycle
        ST_WAIT:
          state <= ST_EMIT;
        ST_EMIT:
          if (wordDone & wordEop)
          begin
            frameCnt <= frameCnt + 1'b1;
            // Stop on last flag or end of memory
            if (lastDesc | (descIdx == DESC_AW'(DESC_DEPTH - 1)))
              state <= ST_IDLE;
            else
            begin
              descIdx <= descIdx + 1'b1;
              state   <= ST_FETCH;
            end
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Frame datapath
  always_ff @(posedge Clk)
  begin
    if (state == ST_WAIT)
    begin
      bytesLeft <= (rdData_i.len == '0) ? LEN_W'(1) : rdData_i.len;
      byteBase  <= rdData_i.seed;
      lastDesc  <= rdData_i.last;
      firstWord <= 1'b1;
    end
    else if (wordDone)
    begin
      bytesLeft <= bytesLeft - LEN_W'(4);
      byteBase  <= byteBase + 8'd4;
      firstWord <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/txFifo.sv
`default_nettype none

module txFifo (
  input  wire        Clk,
  input  wire        reset_i,
  macWordIf.receiver wrSide,
  macWordIf.sender   rdSide
);
  import pktDemoPkg::*;

  macWord_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wrPtr;
  logic [FIFO_AW-1:0] rdPtr;
  logic [FIFO_AW:0]   count;
  logic               push;
  logic               pop;

  //--- Flags and handshakes ---------------------------------------------------

  // Ready means not full
  assign wrSide.ready = (count != (FIFO_AW+1)'(FIFO_DEPTH));

  // Show-ahead head word, wr means not empty
  assign rdSide.wr   = (count != '0);
  assign rdSide.word = mem[rdPtr];

  assign push = wrSide.wr & wrSide.ready;
  assign pop  = rdSide.wr & rdSide.ready;

  // Pointers wrap on power-of-two depth
  always_ff @(posedge Clk)
  begin
    if (reset_i)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      // Simultaneous push and pop leave count alone
      if (push & ~pop)
        count <= count + 1'b1;
      else if (pop & ~push)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge Clk)
  begin
    if (push)
      mem[wrPtr] <= wrSide.word;
  end

endmodule

`default_nettype wire

// File: hw/macTxSerializer.sv
`default_nettype none

module macTxSerializer (
  input  wire        Clk,
  input  wire        reset_i,
  macWordIf.receiver txIn,
  output logic       txEn_o,
  output logic [7:0] txd_o
);
  import pktDemoPkg::*;

  logic [31:0]                     shReg;
  logic [2:0]                      bytesLeft;
  logic                            eopWord;
  logic [$clog2(IFG_CYCLES+1)-1:0] gapCnt;
  logic                            loaded;
  logic                            lastByte;
  logic                            take;

  //--- Pop control ------------------------------------------------------------

  assign loaded   = (bytesLeft != 3'd0);
  assign lastByte = (bytesLeft == 3'd1);

  // Empty shifter or last byte of a mid-frame word
  // Held off while the gap runs
  assign txIn.ready = (gapCnt == '0) & (~loaded | (lastByte & ~eopWord));
  assign take       = txIn.wr & txIn.ready;

  always_ff @(posedge Clk)
  begin
    if (reset_i)
    begin
      bytesLeft <= '0;
      gapCnt    <= '0;
      txEn_o    <= 1'b0;
      txd_o     <= 8'd0;
    end
    else
    begin
      // One byte per cycle, idle drives zero
      txEn_o <= loaded;
      txd_o  <= loaded ? shReg[7:0] : 8'd0;
      if (gapCnt != '0)
        gapCnt <= gapCnt - 1'b1;
      if (take)
      begin
        // Trimmed by be on the last word
        if (txIn.word.eop & (txIn.word.be != 2'd0))
          bytesLeft <= {1'b0, txIn.word.be};
        else
          bytesLeft <= 3'd4;
      end
      else if (loaded)
      begin
        bytesLeft <= bytesLeft - 1'b1;
        // Gap starts with the final byte of the frame
        if (lastByte & eopWord)
          gapCnt <= $bits(gapCnt)'(IFG_CYCLES);
      end
    end
  end

  // Byte shifter, low byte first
  always_ff @(posedge Clk)
  begin
    if (take)
    begin
      shReg   <= txIn.word.data;
      eopWord <= txIn.word.eop;
    end
    else if (loaded)
      shReg <= shReg >> 8;
  end

endmodule

`default_nettype wire

// File: hw/pktDemoTop.sv
`default_nettype none

module pktDemoTop (
  input  wire                         Clk,
  input  wire                         reset_i,
  input  wire                         cyc_i,
  input  wire                         stb_i,
  input  wire                         we_i,
  input  wire [pktDemoPkg::ADR_W-1:0] adr_i,
  input  wire [pktDemoPkg::DAT_W-1:0] dat_i,
  output wire [pktDemoPkg::DAT_W-1:0] dat_o,
  output wire                         ack_o,
  output wire                         txEn_o,
  output wire [7:0]                   txd_o
);
  import pktDemoPkg::*;

  hostBusIf hostBus ();
  macWordIf genToFifo ();
  macWordIf fifoToSer ();

  //--- Host bus clients -------------------------------------------------------

  wire               pdmStb;
  wire               genStb;
  wire [DAT_W-1:0]   pdmDat;
  wire [DAT_W-1:0]   genDat;
  wire               pdmAck;
  wire               genAck;

  // Descriptor read port
  wire               pdmRd;
  wire [DESC_AW-1:0] pdmAddr;
  wire desc_t        pdmRdData;

  hostBusDecoder decoder0 (
    .Clk      (Clk),
    .reset_i  (reset_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .adr_i    (adr_i),
    .dat_i    (dat_i),
    .dat_o    (dat_o),
    .ack_o    (ack_o),
    .bus      (hostBus.decoder),
    .pdmStb_o (pdmStb),
    .genStb_o (genStb),
    .pdmDat_i (pdmDat),
    .pdmAck_i (pdmAck),
    .genDat_i (genDat),
    .genAck_i (genAck)
  );

  descriptorMemory pdm0 (
    .Clk      (Clk),
    .reset_i  (reset_i),
    .bus      (hostBus.client),
    .stb_i    (pdmStb),
    .dat_o    (pdmDat),
    .ack_o    (pdmAck),
    .rd_i     (pdmRd),
    .addr_i   (pdmAddr),
    .rdData_o (pdmRdData)
  );

  packetGenerator gen0 (
    .Clk      (Clk),
    .reset_i  (reset_i),
    .bus      (hostBus.client),
    .stb_i    (genStb),
    .dat_o    (genDat),
    .ack_o    (genAck),
    .rd_o     (pdmRd),
    .addr_o   (pdmAddr),
    .rdData_i (pdmRdData),
    .txOut    (genToFifo.sender)
  );

  //--- Transmit path ----------------------------------------------------------

  txFifo fifo0 (
    .Clk     (Clk),
    .reset_i (reset_i),
    .wrSide  (genToFifo.receiver),
    .rdSide  (fifoToSer.sender)
  );

  macTxSerializer ser0 (
    .Clk     (Clk),
    .reset_i (reset_i),
    .txIn    (fifoToSer.receiver),
    .txEn_o  (txEn_o),
    .txd_o   (txd_o)
  );

endmodule

`default_nettype wire

// File: bench/pktDemo_assert.sv
`default_nettype none

// Protocol checks bound into the top level
module pktDemoAssert (
  input wire Clk,
  input wire reset_i,
  input wire ack_i,
  input wire txEn_i,
  input wire wordWr_i,
  input wire wordReady_i,
  input wire popWr_i,
  input wire popReady_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import pktDemoPkg::*;

  // Low cycles since txEn last dropped, saturating
  // Starts saturated so the first frame passes
  logic [7:0] lowCnt;

  // FIFO occupancy rebuilt from the words that actually moved
  logic [7:0] fill;
  logic       push;
  logic       pop;

  assign push = wordWr_i & wordReady_i;
  assign pop  = popWr_i & popReady_i;

  always_ff @(posedge Clk)
  begin
    if (reset_i)
      lowCnt <= 8'hFF;
    else if (txEn_i)
      lowCnt <= '0;
    else if (lowCnt != 8'hFF)
      lowCnt <= lowCnt + 1'b1;
  end

  always_ff @(posedge Clk)
  begin
    if (reset_i)
      fill <= '0;
    else
      fill <= fill + 8'(push) - 8'(pop);
  end

  // Generator strobe only while the FIFO has room
  wrNeedsRoom: assert property (@(posedge Clk) disable iff (reset_i)
    wordWr_i |-> (fill < 8'(FIFO_DEPTH)))
    else $error("generator word strobe with the FIFO full");

  // Single-cycle ack pulses
  ackOneCycle: assert property (@(posedge Clk) disable iff (reset_i)
    ack_i |=> !ack_i)
    else $error("ack held high for two cycles");

  // Idle gap before each new frame
  gapBeforeFrame: assert property (@(posedge Clk) disable iff (reset_i)
    $rose(txEn_i) |-> (lowCnt >= 8'(IFG_CYCLES)))
    else $error("txEn rose before the inter-frame gap ran out");

endmodule

bind pktDemoTop pktDemoAssert assert0 (
  .Clk         (Clk),
  .reset_i     (reset_i),
  .ack_i       (ack_o),
  .txEn_i      (txEn_o),
  .wordWr_i    (genToFifo.wr),
  .wordReady_i (genToFifo.ready),
  .popWr_i     (fifoToSer.wr),
  .popReady_i  (fifoToSer.ready)
);

`default_nettype wire

// File: bench/pktDemoTb.sv
`default_nettype none

module pktDemoTb;
  timeunit 1ns;
  timeprecision 1ps;
  import pktDemoPkg::*;

  localparam int ACK_TIMEOUT   = 40;
  localparam int POLL_LIMIT    = 4000;
  localparam int DRAIN_TIMEOUT = 20000;

  logic             Clk;
  logic             reset_i;
  logic             busCyc;
  logic             busStb;
  logic             busWe;
  logic [ADR_W-1:0] busAdr;
  logic [DAT_W-1:0] busDat;
  wire  [DAT_W-1:0] rdDat;
  wire              ack;
  wire              txEn;
  wire  [7:0]       txd;

  // Stimulus source and reference state
  logic [31:0]      lfsr;
  logic [DAT_W-1:0] scratchModel [2];
  logic [31:0]      descModel [DESC_DEPTH];
  int               expLen[$];
  int               expSeed[$];
  int               framesExpected = 0;

  // Frame monitor state
  bit inFrame    = 1'b0;
  int byteIdx    = 0;
  int curLen     = 0;
  int curSeed    = 0;
  int gapLen     = 0;
  int framesSeen = 0;

  pktDemoTop dut0 (
    .Clk     (Clk),
    .reset_i (reset_i),
    .cyc_i   (busCyc),
    .stb_i   (busStb),
    .we_i    (busWe),
    .adr_i   (busAdr),
    .dat_i   (busDat),
    .dat_o   (rdDat),
    .ack_o   (ack),
    .txEn_o  (txEn),
    .txd_o   (txd)
  );

  // 8 ns period
  always #4 Clk = ~Clk;

  // ------------------------------------------------------------------------
  // Random numbers and address helpers
  // ------------------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [ADR_W-1:0] hostAddr(input logic [1:0] region,
                                                input logic [12:0] offset);
    return {region, offset};
  endfunction

  // Index in bits 6:1, high half in bit 0
  function automatic logic [ADR_W-1:0] pdmAddr(input int idx, input logic half);
    return {REG_PDM, 6'd0, DESC_AW'(idx), half};
  endfunction

  // Zero length goes out as one byte
  function automatic int frameBytes(input desc_t d);
    return (d.len == '0) ? 1 : int'(d.len);
  endfunction

  // ------------------------------------------------------------------------
  // Failure reporting and compares
  // ------------------------------------------------------------------------

  task automatic stopRun();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportProblem(input string msg);
    $display("t=%0t %s", $time, msg);
    stopRun();
  endtask

  task automatic checkWord(input string what, input logic [DAT_W-1:0] got,
                           input logic [DAT_W-1:0] exp);
    if (got !== exp)
    begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkByte(input string what, input logic [7:0] got,
                           input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  // atLeast turns the compare into a lower bound
  task automatic checkCount(input string what, input int got, input int exp,
                            input bit atLeast);
    if (atLeast ? (got < exp) : (got != exp))
    begin
      $display("FAIL t=%0t %s: got %0d expected %s%0d", $time, what, got,
               atLeast ? "at least " : "", exp);
      stopRun();
    end
  endtask

  // ------------------------------------------------------------------------
  // Host bus tasks
  // ------------------------------------------------------------------------

  // Hold the request until ack, then drop it on that same edge
  task automatic endCycle(input string what, output logic [DAT_W-1:0] data);
    int cycles;
    bit gotAck;
    gotAck = 1'b0;
    cycles = 0;
    data   = '0;
    while (!gotAck && cycles < ACK_TIMEOUT)
    begin
      @(posedge Clk);
      cycles++;
      if (ack)
      begin
        gotAck = 1'b1;
        data   = rdDat;
      end
    end
    busCyc <= 1'b0;
    busStb <= 1'b0;
    busWe  <= 1'b0;
    if (!gotAck)
      reportProblem({"timed out waiting for ack on ", what});
  endtask

  task automatic busWrite(input logic [ADR_W-1:0] a, input logic [DAT_W-1:0] d);
    logic [DAT_W-1:0] unused;
    @(posedge Clk);
    busCyc <= 1'b1;
    busStb <= 1'b1;
    busWe  <= 1'b1;
    busAdr <= a;
    busDat <= d;
    endCycle("bus write", unused);
  endtask

  task automatic busRead(input logic [ADR_W-1:0] a, output logic [DAT_W-1:0] d);
    @(posedge Clk);
    busCyc <= 1'b1;
    busStb <= 1'b1;
    busWe  <= 1'b0;
    busAdr <= a;
    endCycle("bus read", d);
  endtask

  task automatic writeHalf(input int idx, input logic half,
                           input logic [DAT_W-1:0] value);
    busWrite(pdmAddr(idx, half), value);
    if (half)
      descModel[idx][31:16] = value;
    else
      descModel[idx][15:0] = value;
  endtask

  // ------------------------------------------------------------------------
  // Frame runs
  // ------------------------------------------------------------------------

  // Poll status until busy drops
  task automatic waitIdle(output logic [DAT_W-1:0] status);
    int polls;
    polls = 0;
    busRead(hostAddr(REG_GEN, 13'(GEN_STAT)), status);
    while (status[15] && polls < POLL_LIMIT)
    begin
      busRead(hostAddr(REG_GEN, 13'(GEN_STAT)), status);
      polls++;
    end
    if (status[15])
      reportProblem("timed out waiting for generator busy to clear");
  endtask

  // Sampled on the falling edge, away from monitor updates
  task automatic waitFrames();
    int cycles;
    cycles = 0;
    while ((framesSeen != framesExpected || inFrame) && cycles < DRAIN_TIMEOUT)
    begin
      @(negedge Clk);
      cycles++;
    end
    if (framesSeen != framesExpected || inFrame)
      reportProblem("timed out waiting for expected frames on txd");
  endtask

  // Descriptors 0..n-1, last flag only on the final one
  task automatic runFrames(input int n, input int baseLen, input int lenBits,
                           input bit checkBusy);
    desc_t            d;
    logic [DAT_W-1:0] status;
    for (int i = 0; i < n; i++)
    begin
      d      = '0;
      d.len  = LEN_W'(baseLen + int'(randBits(lenBits)));
      d.seed = 8'(randBits(8));
      d.last = (i == n - 1);
      writeHalf(i, 1'b0, d[15:0]);
      writeHalf(i, 1'b1, d[31:16]);
      expLen.push_back(frameBytes(d));
      expSeed.push_back(int'(d.seed));
      framesExpected++;
    end
    busWrite(hostAddr(REG_GEN, 13'(GEN_CTRL)), 16'h0001);
    if (checkBusy)
    begin
      busRead(hostAddr(REG_GEN, 13'(GEN_STAT)), status);
      checkWord("busy during run", status & 16'h8000, 16'h8000);
    end
    waitIdle(status);
    checkWord("frame count in status", status, DAT_W'(n));
    waitFrames();
  endtask

  // ------------------------------------------------------------------------
  // Frame monitor
  // ------------------------------------------------------------------------

  always @(posedge Clk)
  begin
    if (!reset_i)
    begin
      if (txEn)
      begin
        if (!inFrame && expLen.size() == 0)
          reportProblem("frame started on txd with no frame expected");
        else
        begin
          if (!inFrame)
          begin
            // Gap counted in low cycles since the previous frame
            if (framesSeen > 0)
              checkCount("idle gap", gapLen, IFG_CYCLES, 1'b1);
            curLen  = expLen.pop_front();
            curSeed = expSeed.pop_front();
            byteIdx = 0;
            inFrame = 1'b1;
          end
          checkByte($sformatf("frame %0d byte %0d", framesSeen, byteIdx), txd,
                    8'(curSeed + byteIdx));
          byteIdx++;
        end
      end
      else if (inFrame)
      begin
        checkCount($sformatf("frame %0d length", framesSeen), byteIdx, curLen, 1'b0);
        inFrame = 1'b0;
        framesSeen++;
        gapLen = 1;
      end
      else
        gapLen++;
    end
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial
  begin
    logic [DAT_W-1:0] data;
    logic             off;
    logic [DAT_W-1:0] val;
    int               idx;
    int               touched[$];
    Clk     = 1'b0;
    reset_i = 1'b1;
    busCyc  = 1'b0;
    busStb  = 1'b0;
    busWe   = 1'b0;
    busAdr  = '0;
    busDat  = '0;
    lfsr    = 32'hb8d7_f93c;
    scratchModel[0] = SCRATCH0_RST;
    scratchModel[1] = SCRATCH1_RST;
    repeat (16) @(posedge Clk);
    reset_i <= 1'b0;

    // Scratch reset values, then random write and readback
    busRead(hostAddr(REG_SCRATCH, 13'd0), data);
    checkWord("scratch 0 after reset", data, SCRATCH0_RST);
    busRead(hostAddr(REG_SCRATCH, 13'd1), data);
    checkWord("scratch 1 after reset", data, SCRATCH1_RST);
    for (int i = 0; i < 6; i++)
    begin
      off = randBits(1) != 0;
      val = DAT_W'(randBits(16));
      busWrite(hostAddr(REG_SCRATCH, 13'(off)), val);
      scratchModel[off] = val;
      busRead(hostAddr(REG_SCRATCH, 13'(off)), data);
      checkWord("scratch readback", data, scratchModel[off]);
    end

    // Descriptor halves at random indices
    for (int i = 0; i < 12; i++)
    begin
      idx = int'(randBits(DESC_AW));
      writeHalf(idx, 1'b0, DAT_W'(randBits(16)));
      writeHalf(idx, 1'b1, DAT_W'(randBits(16)));
      touched.push_back(idx);
    end
    foreach (touched[i])
    begin
      busRead(pdmAddr(touched[i], 1'b0), data);
      checkWord("descriptor low half", data, descModel[touched[i]][15:0]);
      busRead(pdmAddr(touched[i], 1'b1), data);
      checkWord("descriptor high half", data, descModel[touched[i]][31:16]);
    end

    // One frame, then a short random run, then a long run
    runFrames(1, 1, 6, 1'b0);
    runFrames(2 + int'(randBits(4)) % 9, 0, 7, 1'b0);
    runFrames(10, 200, 6, 1'b1);

    // Unmapped region
    busRead(hostAddr(REG_UNMAPPED, 13'(randBits(13))), data);
    checkWord("unmapped read", data, '0);
    busWrite(hostAddr(REG_UNMAPPED, 13'd0), ~scratchModel[0]);
    busWrite(hostAddr(REG_UNMAPPED, 13'd1), ~scratchModel[1]);
    busWrite(hostAddr(REG_UNMAPPED, 13'd2), ~descModel[1][15:0]);
    busRead(hostAddr(REG_SCRATCH, 13'd0), data);
    checkWord("scratch 0 after unmapped write", data, scratchModel[0]);
    busRead(hostAddr(REG_SCRATCH, 13'd1), data);
    checkWord("scratch 1 after unmapped write", data, scratchModel[1]);
    busRead(pdmAddr(1, 1'b0), data);
    checkWord("descriptor after unmapped write", data, descModel[1][15:0]);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/pktDemoPkg.sv
hw/pktDemoIfs.sv
hw/hostBusDecoder.sv
hw/descriptorMemory.sv
hw/packetGenerator.sv
hw/txFifo.sv
hw/macTxSerializer.sv
hw/pktDemoTop.sv
bench/pktDemo_assert.sv
bench/pktDemoTb.sv

// File: run.sh
#!/bin/sh
# Build the packet demo testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module pktDemoTb -f compile.f -o pktDemoSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pktDemoSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# Pass or fail comes from the log
if grep -q "RESULT: FAIL" sim.log; then
  echo "failure reported in sim.log"
  exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
  echo "no pass line in sim.log"
  exit 1
fi

exit 0
